// ==== hw/ex_pkg.sv ====
// Shared types for the execute stage
// Word, register address and bit-mask widths
// ALU and multiplier operator encodings, multiplier FSM states
// Request structs for ALU and multiplier, register write port struct

package ex_pkg;

  // Data word for operands, results and load data
  typedef logic [31:0] word_t;
  // Register file write address (6 bits, room for FP registers)
  typedef logic [5:0]  regaddr_t;
  // Bit-field position or field length minus one
  typedef logic [4:0]  bmask_t;

  ////////////////////////////////////////////////////////////
  // Operator encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    ADD   = 5'd0,
    SUB   = 5'd1,
    AND   = 5'd2,
    OR    = 5'd3,
    XOR   = 5'd4,
    SLL   = 5'd5,
    SRL   = 5'd6,
    SRA   = 5'd7,
    SLT   = 5'd8,
    SLTU  = 5'd9,
    EQ    = 5'd10,
    NE    = 5'd11,
    LT    = 5'd12,
    GE    = 5'd13,
    LTU   = 5'd14,
    GEU   = 5'd15,
    BEXT  = 5'd16,
    BEXTU = 5'd17,
    BINS  = 5'd18,
    BCLR  = 5'd19,
    BSET  = 5'd20
  } alu_op_e;

  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mult_op_e;

  // Multiplier sequencing, HIGH holds the upper product
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    HIGH = 2'd1
  } mult_state_e;

  ////////////////////////////////////////////////////////////
  // Request and write-port bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    alu_op_e op;
    word_t   a;
    word_t   b;
    word_t   c;
    bmask_t  bmask_a;
    bmask_t  bmask_b;
  } alu_req_t;

  typedef struct packed {
    mult_op_e op;
    word_t    a;
    word_t    b;
  } mult_req_t;

  typedef struct packed {
    logic     we;
    regaddr_t waddr;
    word_t    wdata;
  } wb_port_t;

endpackage

// ==== hw/ex_alu.sv ====
// Combinational integer ALU
// Shared adder for add, subtract and all compares
// Single right barrel shifter with bit reversal for left shifts
// Bit-field extract, insert, clear and set

`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::alu_req_t alu_req_i,
  output ex_pkg::word_t    result_o,
  output logic             cmp_result_o
);

  // Mirror a word so one right shifter also does left shifts
  function automatic ex_pkg::word_t bit_reverse(input ex_pkg::word_t v);
    ex_pkg::word_t r;
    for (int i = 0; i < 32; i++) begin
      r[i] = v[31-i];
    end
    return r;
  endfunction

  ex_pkg::alu_op_e op;
  ex_pkg::word_t   op_a;
  ex_pkg::word_t   op_b;
  ex_pkg::word_t   op_c;

  // Adder and compare flags
  logic            do_sub;
  ex_pkg::word_t   add_b;
  logic [32:0]     add_sum;
  logic            is_eq;
  logic            is_lt;
  logic            is_ltu;

  // Shifter
  logic            shift_left;
  logic            shift_arith;
  ex_pkg::word_t   shift_in;
  logic [32:0]     shift_ext;
  ex_pkg::word_t   shift_res;

  // Bit-field unit
  ex_pkg::word_t   bf_ones;
  ex_pkg::word_t   bf_mask;
  ex_pkg::word_t   bf_field;
  ex_pkg::word_t   bf_ext;

  assign op   = alu_req_i.op;
  assign op_a = alu_req_i.a;
  assign op_b = alu_req_i.b;
  assign op_c = alu_req_i.c;

  ////////////////////////////////////////////////////////////
  // Shared adder
  ////////////////////////////////////////////////////////////

  // Subtract for SUB and every compare
  assign do_sub = op inside {ex_pkg::SUB, ex_pkg::SLT, ex_pkg::SLTU, ex_pkg::EQ,
                             ex_pkg::NE, ex_pkg::LT, ex_pkg::GE, ex_pkg::LTU,
                             ex_pkg::GEU};
  assign add_b   = do_sub ? ~op_b : op_b;
  assign add_sum = {1'b0, op_a} + {1'b0, add_b} + {32'd0, do_sub};

  // Zero difference means equal
  assign is_eq  = (add_sum[31:0] == 32'd0);
  // No carry out of a - b means a < b unsigned
  assign is_ltu = ~add_sum[32];
  // Signs differ: negative one is smaller, else the difference sign decides
  assign is_lt  = (op_a[31] ^ op_b[31]) ? op_a[31] : add_sum[31];

  ////////////////////////////////////////////////////////////
  // Barrel shifter
  ////////////////////////////////////////////////////////////

  assign shift_left  = (op == ex_pkg::SLL);
  assign shift_arith = (op == ex_pkg::SRA);
  assign shift_in    = shift_left ? bit_reverse(op_a) : op_a;
  // Extra top bit carries the sign for SRA, zero otherwise
  assign shift_ext   = $signed({shift_arith & shift_in[31], shift_in}) >>> op_b[4:0];
  assign shift_res   = shift_left ? bit_reverse(shift_ext[31:0]) : shift_ext[31:0];

  ////////////////////////////////////////////////////////////
  // Bit-field unit
  ////////////////////////////////////////////////////////////

  // bmask_a + 1 ones at the bottom
  assign bf_ones  = 32'hFFFF_FFFF >> (5'd31 - alu_req_i.bmask_a);
  // Field mask placed at start bit bmask_b
  assign bf_mask  = bf_ones << alu_req_i.bmask_b;
  // Field moved down to bit 0
  assign bf_field = (op_a >> alu_req_i.bmask_b) & bf_ones;
  // Sign extension from the top bit of the field
  assign bf_ext   = bf_field[alu_req_i.bmask_a] ? (bf_field | ~bf_ones) : bf_field;

  // Compare flag, also the branch decision
  always_comb begin
    case (op)
      ex_pkg::EQ:                cmp_result_o = is_eq;
      ex_pkg::NE:                cmp_result_o = ~is_eq;
      ex_pkg::SLT, ex_pkg::LT:   cmp_result_o = is_lt;
      ex_pkg::GE:                cmp_result_o = ~is_lt;
      ex_pkg::SLTU, ex_pkg::LTU: cmp_result_o = is_ltu;
      ex_pkg::GEU:               cmp_result_o = ~is_ltu;
      default:                   cmp_result_o = 1'b0;
    endcase
  end

  // Result select
  always_comb begin
    case (op)
      ex_pkg::ADD,
      ex_pkg::SUB:   result_o = add_sum[31:0];
      ex_pkg::AND:   result_o = op_a & op_b;
      ex_pkg::OR:    result_o = op_a | op_b;
      ex_pkg::XOR:   result_o = op_a ^ op_b;
      ex_pkg::SLL,
      ex_pkg::SRL,
      ex_pkg::SRA:   result_o = shift_res;
      ex_pkg::SLT, ex_pkg::SLTU, ex_pkg::EQ, ex_pkg::NE,
      ex_pkg::LT, ex_pkg::GE, ex_pkg::LTU,
      ex_pkg::GEU:   result_o = {31'd0, cmp_result_o};
      ex_pkg::BEXT:  result_o = bf_ext;
      ex_pkg::BEXTU: result_o = bf_field;
      // Insert the low bits of a into the old value in c
      ex_pkg::BINS:  result_o = ((op_a << alu_req_i.bmask_b) & bf_mask) | (op_c & ~bf_mask);
      ex_pkg::BCLR:  result_o = op_a & ~bf_mask;
      ex_pkg::BSET:  result_o = op_a | bf_mask;
      default:       result_o = 32'd0;
    endcase
  end

endmodule

// ==== hw/ex_mult.sv ====
// 32x32 integer multiplier built from 17-bit signed halves
// MUL low product in the same cycle
// MULH, MULHSU, MULHU in two cycles under an IDLE/HIGH FSM

`timescale 1ns/1ps

module ex_mult (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable_i,
  input  ex_pkg::mult_req_t mult_req_i,
  input  logic              ex_ready_i,
  output ex_pkg::word_t     result_o,
  output logic              ready_o,
  output logic              multicycle_o
);

  // Operand signedness per operator
  logic                a_signed;
  logic                b_signed;
  logic                high_op;

  // Halves, low halves zero-extended, high halves sign-extended on demand
  logic signed [16:0]  a_hi;
  logic signed [16:0]  a_lo;
  logic signed [16:0]  b_hi;
  logic signed [16:0]  b_lo;

  // Partial products
  logic signed [33:0]  pp_hh;
  logic signed [33:0]  pp_hl;
  logic signed [33:0]  pp_lh;
  logic signed [33:0]  pp_ll;

  // Registered partial products for the high half
  logic signed [33:0]  pp_hh_q;
  logic signed [33:0]  pp_hl_q;
  logic signed [33:0]  pp_lh_q;
  logic [31:0]         pp_ll_q;

  ex_pkg::word_t       low_result;
  logic [63:0]         high_sum;
  ex_pkg::mult_state_e state_q;
  ex_pkg::mult_state_e state_d;

  assign a_signed = mult_req_i.op inside {ex_pkg::MULH, ex_pkg::MULHSU};
  assign b_signed = (mult_req_i.op == ex_pkg::MULH);
  assign high_op  = (mult_req_i.op != ex_pkg::MUL);

  assign a_hi = {a_signed & mult_req_i.a[31], mult_req_i.a[31:16]};
  assign a_lo = {1'b0, mult_req_i.a[15:0]};
  assign b_hi = {b_signed & mult_req_i.b[31], mult_req_i.b[31:16]};
  assign b_lo = {1'b0, mult_req_i.b[15:0]};

  assign pp_hh = a_hi * b_hi;
  assign pp_hl = a_hi * b_lo;
  assign pp_lh = a_lo * b_hi;
  assign pp_ll = a_lo * b_lo;

  // Low word only needs the bottom 16 bits of the cross terms
  assign low_result = pp_ll[31:0] + {pp_hl[15:0] + pp_lh[15:0], 16'h0000};

  // Full 64-bit sum of the registered terms
  assign high_sum = {pp_hh_q[31:0], 32'h0000_0000}
                  + {{14{pp_hl_q[33]}}, pp_hl_q, 16'h0000}
                  + {{14{pp_lh_q[33]}}, pp_lh_q, 16'h0000}
                  + {32'h0000_0000, pp_ll_q};

  ////////////////////////////////////////////////////////////
  // Sequencing FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;
    result_o     = low_result;
    case (state_q)
      ex_pkg::IDLE: begin
        // High op seen, stall one cycle while products settle in registers
        if (enable_i && high_op) begin
          ready_o = 1'b0;
          state_d = ex_pkg::HIGH;
        end
      end
      ex_pkg::HIGH: begin
        multicycle_o = 1'b1;
        result_o     = high_sum[63:32];
        // Hold the result until the stage moves on
        if (ex_ready_i) begin
          state_d = ex_pkg::IDLE;
        end
      end
      default: state_d = ex_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture products on the stall cycle only
  always_ff @(posedge clk) begin
    if (state_q == ex_pkg::IDLE && enable_i && high_op) begin
      pp_hh_q <= pp_hh;
      pp_hl_q <= pp_hl;
      pp_lh_q <= pp_lh;
      pp_ll_q <= pp_ll[31:0];
    end
  end

endmodule

// ==== hw/ex_wb_ports.sv ====
// Register file write ports of the execute stage
// Forwarding port with CSR, multiplier and ALU result select
// Load port with the EX/WB destination register

`timescale 1ns/1ps

module ex_wb_ports (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             alu_en_i,
  input  logic             mult_en_i,
  input  logic             csr_access_i,
  input  ex_pkg::word_t    alu_result_i,
  input  ex_pkg::word_t    mult_result_i,
  input  ex_pkg::word_t    csr_rdata_i,
  input  ex_pkg::word_t    lsu_rdata_i,
  input  logic             regfile_alu_we_i,
  input  ex_pkg::regaddr_t regfile_alu_waddr_i,
  input  logic             regfile_we_i,
  input  ex_pkg::regaddr_t regfile_waddr_i,
  input  logic             lsu_err_i,
  input  logic             ex_valid_i,
  input  logic             wb_ready_i,
  output ex_pkg::wb_port_t fw_port_o,
  output ex_pkg::wb_port_t wb_port_o
);

  // Load destination held for WB
  logic             lsu_we_q;
  ex_pkg::regaddr_t lsu_waddr_q;

  ////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////

  always_comb begin
    fw_port_o.we    = regfile_alu_we_i;
    fw_port_o.waddr = regfile_alu_waddr_i;
    // CSR first, then multiplier, then ALU
    if (csr_access_i) begin
      fw_port_o.wdata = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_port_o.wdata = mult_result_i;
    end else if (alu_en_i) begin
      fw_port_o.wdata = alu_result_i;
    end else begin
      fw_port_o.wdata = 32'd0;
    end
  end

  ////////////////////////////////////////////////////////////
  // EX/WB register for the load port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid_i) begin
      // Faulting load never reaches the register file
      lsu_we_q <= regfile_we_i & ~lsu_err_i;
      if (regfile_we_i && !lsu_err_i) begin
        lsu_waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Bubble: WB drained, nothing new from EX
      lsu_we_q <= 1'b0;
    end
  end

  // Load data arrives from the LSU in the WB cycle
  assign wb_port_o.we    = lsu_we_q;
  assign wb_port_o.waddr = lsu_waddr_q;
  assign wb_port_o.wdata = lsu_rdata_i;

endmodule

// ==== hw/ex_stage.sv ====
// Execute stage top level
// ALU, multiplier and write-port instances
// Ready/valid stall control, branch decision and jump target

`timescale 1ns/1ps

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  // ALU request from ID
  input  logic              alu_en_i,
  input  ex_pkg::alu_req_t  alu_req_i,
  // Multiplier request from ID
  input  logic              mult_en_i,
  input  ex_pkg::mult_req_t mult_req_i,
  // CSR read result
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  // LSU
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  // Destinations from ID
  input  logic              branch_in_ex_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::regaddr_t  regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::regaddr_t  regfile_waddr_i,
  // Back-pressure from WB
  input  logic              wb_ready_i,
  // Write ports
  output ex_pkg::wb_port_t  fw_port_o,
  output ex_pkg::wb_port_t  wb_port_o,
  output logic              mult_multicycle_o,
  // To IF
  output logic              branch_decision_o,
  output ex_pkg::word_t     jump_target_o,
  // Stall control
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  ex_pkg::word_t alu_result;
  logic          alu_cmp_result;
  ex_pkg::word_t mult_result;
  logic          mult_ready;

  ex_alu u_alu (
    .alu_req_i    (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .mult_req_i   (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_wb_ports u_wb_ports (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en_i),
    .mult_en_i           (mult_en_i),
    .csr_access_i        (csr_access_i),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .lsu_err_i           (lsu_err_i),
    .ex_valid_i          (ex_valid_o),
    .wb_ready_i          (wb_ready_i),
    .fw_port_o           (fw_port_o),
    .wb_port_o           (wb_port_o)
  );

  ////////////////////////////////////////////////////////////
  // Branch outputs and stall control
  ////////////////////////////////////////////////////////////

  // Branch target comes in on operand c
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_req_i.c;

  // Branches finish in EX and do not wait for WB
  assign ex_ready_o = (mult_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  // Valid does not look at ready, so no loop through the branch term
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                    & mult_ready & lsu_ready_ex_i & wb_ready_i;

endmodule

// ==== test/ex_stage_tb.sv ====
// Testbench for the execute stage
// Vectors and expected results come from test/ex_testdata.txt
// ALU, compares, bit-field ops, multiplier, CSR, loads and back-pressure

`timescale 1ns/1ps

module ex_stage_tb;

  localparam int          MAX_VEC        = 64;
  localparam int          RESET_CYCLES   = 16;
  localparam int          CYCLES_PER_VEC = 20;
  localparam int          MAX_WAIT       = 8;
  localparam logic [31:0] SEED           = 32'h41b2f140;

  // Test kinds
  localparam int K_ALU   = 0;
  localparam int K_MULT  = 1;
  localparam int K_CSR   = 2;
  localparam int K_LOAD  = 3;
  localparam int K_STALL = 4;

  logic              clk;
  logic              rst_n;
  logic              alu_en_i;
  ex_pkg::alu_req_t  alu_req_i;
  logic              mult_en_i;
  ex_pkg::mult_req_t mult_req_i;
  logic              csr_access_i;
  ex_pkg::word_t     csr_rdata_i;
  logic              lsu_en_i;
  ex_pkg::word_t     lsu_rdata_i;
  logic              lsu_ready_ex_i;
  logic              lsu_err_i;
  logic              branch_in_ex_i;
  logic              regfile_alu_we_i;
  ex_pkg::regaddr_t  regfile_alu_waddr_i;
  logic              regfile_we_i;
  ex_pkg::regaddr_t  regfile_waddr_i;
  logic              wb_ready_i;
  ex_pkg::wb_port_t  fw_port_o;
  ex_pkg::wb_port_t  wb_port_o;
  logic              mult_multicycle_o;
  logic              branch_decision_o;
  ex_pkg::word_t     jump_target_o;
  logic              ex_ready_o;
  logic              ex_valid_o;

  // Vector table, one entry per data line
  int          vec_id     [MAX_VEC];
  logic [63:0] vec_kind   [MAX_VEC];
  logic [7:0]  vec_op     [MAX_VEC];
  logic [31:0] vec_a      [MAX_VEC];
  logic [31:0] vec_b      [MAX_VEC];
  logic [31:0] vec_c      [MAX_VEC];
  logic [4:0]  vec_bma    [MAX_VEC];
  logic [4:0]  vec_bmb    [MAX_VEC];
  logic        vec_we     [MAX_VEC];
  logic [5:0]  vec_waddr  [MAX_VEC];
  logic        vec_err    [MAX_VEC];
  logic [31:0] vec_exp    [MAX_VEC];
  logic        vec_flag   [MAX_VEC];
  int          vec_cycles [MAX_VEC];

  int          num_vec;
  bit          loaded;
  int          cur_id;
  int          test_errors;
  int          total_errors;
  int          tests_failed;
  logic [31:0] rnd_state;

  ex_stage dut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en_i),
    .alu_req_i           (alu_req_i),
    .mult_en_i           (mult_en_i),
    .mult_req_i          (mult_req_i),
    .csr_access_i        (csr_access_i),
    .csr_rdata_i         (csr_rdata_i),
    .lsu_en_i            (lsu_en_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .lsu_err_i           (lsu_err_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .wb_ready_i          (wb_ready_i),
    .fw_port_o           (fw_port_o),
    .wb_port_o           (wb_port_o),
    .mult_multicycle_o   (mult_multicycle_o),
    .branch_decision_o   (branch_decision_o),
    .jump_target_o       (jump_target_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

  ////////////////////////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Budget grows with the vector count
  initial begin
    wait (loaded);
    repeat (num_vec * CYCLES_PER_VEC + RESET_CYCLES) @(posedge clk);
    $display("Watchdog expired, run exceeded %0d cycles",
             num_vec * CYCLES_PER_VEC + RESET_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int kind_code(input logic [63:0] s);
    if (s == 64'("alu"))   return K_ALU;
    if (s == 64'("mult"))  return K_MULT;
    if (s == 64'("csr"))   return K_CSR;
    if (s == 64'("load"))  return K_LOAD;
    if (s == 64'("stall")) return K_STALL;
    return -1;
  endfunction

  // EQ through GEU steer a branch
  function automatic bit is_branch_op(input logic [7:0] op);
    return (op >= 8'h0a) && (op <= 8'h0f);
  endfunction

  task automatic mismatch(input string msg);
    $display("Mismatch at %0t: test %0d, %s", $time, cur_id, msg);
    test_errors++;
  endtask

  // Idle values, LSU always ready and WB draining
  task automatic clear_inputs();
    alu_en_i            = 1'b0;
    alu_req_i           = '0;
    mult_en_i           = 1'b0;
    mult_req_i          = '0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    branch_in_ex_i      = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    wb_ready_i          = 1'b1;
  endtask

  task automatic load_vectors();
    int    fd;
    int    code;
    int    n;
    string line;
    fd = $fopen("test/ex_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file test/ex_testdata.txt");
      total_errors++;
    end else begin
      while (!$feof(fd) && num_vec < MAX_VEC) begin
        code = $fgets(line, fd);
        // Skip comment and blank lines
        if (code > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%d %s %h %h %h %h %h %h %h %h %h %h %h %d",
                      vec_id[num_vec], vec_kind[num_vec], vec_op[num_vec],
                      vec_a[num_vec], vec_b[num_vec], vec_c[num_vec],
                      vec_bma[num_vec], vec_bmb[num_vec], vec_we[num_vec],
                      vec_waddr[num_vec], vec_err[num_vec], vec_exp[num_vec],
                      vec_flag[num_vec], vec_cycles[num_vec]);
          if (n == 14) begin
            num_vec++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_vector(input int i, input int kind);
    case (kind)
      K_ALU, K_STALL: begin
        alu_en_i          = 1'b1;
        alu_req_i.op      = ex_pkg::alu_op_e'(vec_op[i][4:0]);
        alu_req_i.a       = vec_a[i];
        alu_req_i.b       = vec_b[i];
        alu_req_i.c       = vec_c[i];
        alu_req_i.bmask_a = vec_bma[i];
        alu_req_i.bmask_b = vec_bmb[i];
        branch_in_ex_i    = is_branch_op(vec_op[i]);
      end
      K_MULT: begin
        mult_en_i     = 1'b1;
        mult_req_i.op = ex_pkg::mult_op_e'(vec_op[i][1:0]);
        mult_req_i.a  = vec_a[i];
        mult_req_i.b  = vec_b[i];
      end
      K_CSR: begin
        csr_access_i = 1'b1;
        csr_rdata_i  = vec_a[i];
      end
      default: begin
        // Load, destination goes through the EX/WB register
        lsu_en_i        = 1'b1;
        lsu_rdata_i     = vec_a[i];
        lsu_err_i       = vec_err[i];
        regfile_we_i    = vec_we[i];
        regfile_waddr_i = vec_waddr[i];
      end
    endcase
    if (kind != K_LOAD) begin
      regfile_alu_we_i    = vec_we[i];
      regfile_alu_waddr_i = vec_waddr[i];
    end
  endtask

  // Checks in the cycle where ex_ready_o is high
  task automatic check_result(input int i, input int kind);
    if (ex_valid_o !== 1'b1) mismatch("ex_valid_o low in completion cycle");
    if (kind != K_LOAD) begin
      if (fw_port_o.we !== vec_we[i]) mismatch("fw_port we wrong");
      if (fw_port_o.waddr !== vec_waddr[i]) mismatch("fw_port waddr wrong");
      if (fw_port_o.wdata !== vec_exp[i]) begin
        mismatch($sformatf("fw_port wdata %h, expected %h", fw_port_o.wdata, vec_exp[i]));
      end
    end
    if (kind == K_ALU || kind == K_STALL) begin
      if (branch_decision_o !== vec_flag[i]) mismatch("branch_decision_o wrong");
      if (jump_target_o !== vec_c[i]) mismatch("jump_target_o differs from operand c");
    end
    if (kind == K_MULT) begin
      if (mult_multicycle_o !== (vec_cycles[i] > 1)) mismatch("mult_multicycle_o wrong");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One vector from drive to final check
  ////////////////////////////////////////////////////////////

  task automatic run_vector(input int i);
    int kind;
    int cycles;
    int stall_len;
    bit done;
    kind        = kind_code(vec_kind[i]);
    cur_id      = vec_id[i];
    test_errors = 0;
    if (kind < 0) begin
      $display("Test %0d has an unknown kind and was not run", cur_id);
      test_errors++;
    end else begin
      @(posedge clk);
      #1;
      drive_vector(i, kind);
      // Branch resolves in EX even with WB stalled
      if (kind == K_ALU && is_branch_op(vec_op[i])) begin
        wb_ready_i = 1'b0;
        #1;
        if (ex_ready_o !== 1'b1) mismatch("ex_ready_o low for a branch while WB stalled");
        if (ex_valid_o !== 1'b0) mismatch("ex_valid_o high while WB stalled");
        wb_ready_i = 1'b1;
      end
      // WB back-pressure for a random number of cycles
      if (kind == K_STALL) begin
        rnd_state  = xorshift32(rnd_state);
        stall_len  = int'(rnd_state[1:0]) + 1;
        wb_ready_i = 1'b0;
        for (int k = 0; k < stall_len; k++) begin
          @(negedge clk);
          if (ex_valid_o !== 1'b0) mismatch("ex_valid_o high while WB stalled");
          if (ex_ready_o !== 1'b0) mismatch("ex_ready_o high while WB stalled");
          @(posedge clk);
          #1;
        end
        wb_ready_i = 1'b1;
      end
      cycles = 0;
      done   = 1'b0;
      while (!done && cycles < MAX_WAIT) begin
        @(negedge clk);
        cycles++;
        if (ex_ready_o === 1'b1) begin
          done = 1'b1;
        end else begin
          if (ex_valid_o !== 1'b0) mismatch("ex_valid_o high while not ready");
          @(posedge clk);
          #1;
        end
      end
      if (!done) begin
        $display("Test %0d: ex_ready_o never rose within %0d cycles", cur_id, MAX_WAIT);
        test_errors++;
      end else begin
        if (cycles != vec_cycles[i]) begin
          mismatch($sformatf("took %0d cycles, expected %0d", cycles, vec_cycles[i]));
        end
        check_result(i, kind);
      end
      @(posedge clk);
      #1;
      clear_inputs();
      // Load port one cycle after ex_valid_o, data straight from the LSU
      if (kind == K_LOAD) begin
        lsu_rdata_i = vec_a[i];
        @(negedge clk);
        if (wb_port_o.we !== vec_flag[i]) mismatch("wb_port we wrong");
        if (vec_flag[i] && wb_port_o.waddr !== vec_waddr[i]) mismatch("wb_port waddr wrong");
        if (wb_port_o.wdata !== vec_exp[i]) begin
          mismatch($sformatf("wb_port wdata %h, expected %h", wb_port_o.wdata, vec_exp[i]));
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    clear_inputs();
    rst_n        = 1'b0;
    rnd_state    = SEED;
    num_vec      = 0;
    total_errors = 0;
    tests_failed = 0;
    load_vectors();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Reset state of load port and multiplier
    cur_id      = 0;
    test_errors = 0;
    @(negedge clk);
    if (wb_port_o.we !== 1'b0) mismatch("wb_port we high after reset");
    if (wb_port_o.waddr !== 6'd0) mismatch("wb_port waddr nonzero after reset");
    if (mult_multicycle_o !== 1'b0) mismatch("mult_multicycle_o high after reset");
    if (ex_ready_o !== 1'b1) mismatch("ex_ready_o low after reset");
    $display("Reset check done, %0d errors", test_errors);
    total_errors += test_errors;
    for (int i = 0; i < num_vec; i++) begin
      run_vector(i);
      if (test_errors == 0) begin
        $display("Test %0d passed", cur_id);
      end else begin
        $display("Test %0d failed with %0d errors", cur_id, test_errors);
        tests_failed++;
      end
      total_errors += test_errors;
    end
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             num_vec, num_vec - tests_failed, tests_failed, total_errors);
    if (total_errors == 0 && tests_failed == 0 && num_vec > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== test/ex_testdata.txt ====
# id kind op a b c bmask_a bmask_b we waddr err exp_data exp_flag exp_cycles
# id and exp_cycles decimal, rest hex; exp_flag is the branch flag, for loads the wb_port we
1 alu 00 00001234 00005678 00000000 00 00 1 01 0 000068ac 0 1
2 alu 01 00000010 00000020 00000000 00 00 1 02 0 fffffff0 0 1
3 alu 00 ffffffff 00000002 00000000 00 00 1 03 0 00000001 0 1
4 alu 02 f0f0f0f0 ff00ff00 00000000 00 00 1 04 0 f000f000 0 1
5 alu 03 f0f0f0f0 0f0f0000 00000000 00 00 1 05 0 fffff0f0 0 1
6 alu 04 aaaa5555 ffff0000 00000000 00 00 1 06 0 55555555 0 1
7 alu 05 00000001 0000001f 00000000 00 00 1 07 0 80000000 0 1
8 alu 05 12345678 00000004 00000000 00 00 1 08 0 23456780 0 1
9 alu 06 80000000 00000004 00000000 00 00 1 09 0 08000000 0 1
10 alu 07 80000000 00000004 00000000 00 00 1 0a 0 f8000000 0 1
11 alu 07 7ffffff0 00000024 00000000 00 00 1 0b 0 07ffffff 0 1
12 alu 08 ffffffff 00000001 00000000 00 00 1 0c 0 00000001 1 1
13 alu 09 ffffffff 00000001 00000000 00 00 1 0d 0 00000000 0 1
14 alu 0a 12345678 12345678 00000400 00 00 0 00 0 00000001 1 1
15 alu 0b 12345678 12345678 00000800 00 00 0 00 0 00000000 0 1
16 alu 0c 80000000 7fffffff 00000c00 00 00 0 00 0 00000001 1 1
17 alu 0d 00000005 fffffffb 00001000 00 00 0 00 0 00000001 1 1
18 alu 0e 00000005 fffffffb 00001400 00 00 0 00 0 00000001 1 1
19 alu 0f 00000005 fffffffb 00001800 00 00 0 00 0 00000000 0 1
20 alu 10 0000f000 00000000 00000000 03 0c 1 0e 0 ffffffff 0 1
21 alu 11 0000f000 00000000 00000000 03 0c 1 0f 0 0000000f 0 1
22 alu 10 00007000 00000000 00000000 03 0c 1 10 0 00000007 0 1
23 alu 12 000000ab 00000000 ffffffff 07 08 1 11 0 ffffabff 0 1
24 alu 13 ffffffff 00000000 00000000 03 04 1 12 0 ffffff0f 0 1
25 alu 14 00000000 00000000 00000000 0f 10 1 13 0 ffff0000 0 1
26 alu 11 deadbeef 00000000 00000000 1f 00 1 14 0 deadbeef 0 1
27 mult 00 00001234 00005678 00000000 00 00 1 15 0 06260060 0 1
28 mult 00 ffffffff ffffffff 00000000 00 00 1 16 0 00000001 0 1
29 mult 01 ffffffff ffffffff 00000000 00 00 1 17 0 00000000 0 2
30 mult 03 ffffffff ffffffff 00000000 00 00 1 18 0 fffffffe 0 2
31 mult 02 ffffffff ffffffff 00000000 00 00 1 19 0 ffffffff 0 2
32 mult 01 80000000 80000000 00000000 00 00 1 1a 0 40000000 0 2
33 mult 03 00010000 00010000 00000000 00 00 1 1b 0 00000001 0 2
34 mult 01 80000000 00000002 00000000 00 00 1 1c 0 ffffffff 0 2
35 mult 02 80000000 80000000 00000000 00 00 1 1d 0 c0000000 0 2
36 csr 00 cafe0001 00000000 00000000 00 00 1 05 0 cafe0001 0 1
37 csr 00 00000300 00000000 00000000 00 00 1 1f 0 00000300 0 1
38 load 00 deadbeef 00000000 00000000 00 00 1 0a 0 deadbeef 1 1
39 load 00 01234567 00000000 00000000 00 00 1 0b 1 01234567 0 1
40 load 00 00000042 00000000 00000000 00 00 0 0c 0 00000042 0 1
41 stall 00 00000100 00000200 00000000 00 00 1 20 0 00000300 0 1
42 stall 04 0f0f0f0f ffffffff 00000000 00 00 1 21 0 f0f0f0f0 0 1
43 stall 05 00000003 00000002 00000000 00 00 1 22 0 0000000c 0 1

// ==== verilog.f ====
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_mult.sv
hw/ex_wb_ports.sv
hw/ex_stage.sv
test/ex_stage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module ex_stage_tb -o ex_stage_sim

output=$(./obj_dir/ex_stage_sim)
echo "$output"

if echo "$output" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
